/* tb.f */
verilog/rv_operand_pkg.sv
verilog/register_file.sv
verilog/hazard_stall_unit.sv
verilog/forwarding_select_unit.sv
verilog/decode_issue.sv
verilog/operand_supply_top.sv
bench/tb_operand_supply.sv

/* Bender.yml */
package:
  name: operand_supply

sources:
  - verilog/rv_operand_pkg.sv
  - verilog/register_file.sv
  - verilog/hazard_stall_unit.sv
  - verilog/forwarding_select_unit.sv
  - verilog/decode_issue.sv
  - verilog/operand_supply_top.sv
  - target: simulation
    files:
      - bench/tb_operand_supply.sv

/* bench/tb_operand_supply.sv */
// random-stimulus testbench for operand_supply_top, checking controls and the issue bundle
module tb_operand_supply;
    import rv_operand_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int TOTAL_CHECKS = 32 + NUM_RANDOM;

    // expected combinational controls plus the bundle they lead to
    typedef struct packed {
        logic   pc_write_en;
        logic   if_kill;
        issue_t issue;
    } expect_t;

    logic        clk;
    logic        arst_n;
    instr_u      if_instr;
    dec_ctrl_t   dec;
    stage_wr_t   exe_wr;
    stage_wr_t   mem_wr;
    stage_wr_t   wb_wr;
    logic [31:0] exe_alu_out;
    logic [31:0] mem_result;
    logic [31:0] wb_data;
    logic        branch_taken;
    logic        pc_write_en;
    logic        if_kill;
    issue_t      issue;

    integer      seed;
    logic [31:0] shadow [0:31];
    int          control_errors;
    int          issue_errors;
    int          timeout_errors;
    int          issue_checks;

    operand_supply_top #(
        .XLEN(32)
    ) i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .if_instr    (if_instr),
        .dec         (dec),
        .exe_wr      (exe_wr),
        .mem_wr      (mem_wr),
        .wb_wr       (wb_wr),
        .exe_alu_out (exe_alu_out),
        .mem_result  (mem_result),
        .wb_data     (wb_data),
        .branch_taken(branch_taken),
        .pc_write_en (pc_write_en),
        .if_kill     (if_kill),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // does this stage hold a usable result for register a
    function automatic logic stage_claims(stage_wr_t c, reg_addr_t a, logic load_ok);
        logic producer;
        producer = (c.wb_sel == wb_alu_out) || (load_ok && c.wb_sel == wb_mem_read_data);
        return c.wr_en && (c.wr_addr != 5'd0) && (c.wr_addr == a) && producer;
    endfunction

    function automatic expect_t ref_issue(
        input logic [31:0] if_word,
        input dec_ctrl_t   d,
        input stage_wr_t   ew,
        input stage_wr_t   mw,
        input stage_wr_t   ww,
        input logic [31:0] exe_v,
        input logic [31:0] mem_v,
        input logic [31:0] wb_v,
        input logic        br
    );
        expect_t     e;
        logic [31:0] w;
        logic [31:0] op1;
        logic [31:0] rs2_fwd;
        logic [31:0] st_fwd;
        logic        stall;
        logic        kill_dec;
        w = d.instr;
        stall = d.wr_en && (d.wb_sel == wb_mem_read_data) && (w[11:7] != 5'd0) &&
                ((w[11:7] == if_word[19:15]) || (w[11:7] == if_word[24:20]));
        e.pc_write_en = br || !stall;
        e.if_kill     = br || stall;
        kill_dec      = br;
        // oldest first, so the youngest matching stage wins
        op1 = shadow[w[19:15]];
        if (stage_claims(ww, w[19:15], 1'b1)) op1 = wb_v;
        if (stage_claims(mw, w[19:15], 1'b1)) op1 = mem_v;
        if (stage_claims(ew, w[19:15], 1'b0)) op1 = exe_v;
        rs2_fwd = shadow[w[24:20]];
        if (stage_claims(ww, w[24:20], 1'b1)) rs2_fwd = wb_v;
        if (stage_claims(mw, w[24:20], 1'b1)) rs2_fwd = mem_v;
        st_fwd = rs2_fwd;
        if (stage_claims(ew, w[24:20], 1'b0)) rs2_fwd = exe_v;
        e.issue.valid  = !kill_dec;
        e.issue.op1    = op1;
        e.issue.rd     = w[11:7];
        e.issue.wr_en  = d.wr_en;
        e.issue.wb_sel = d.wb_sel;
        // store data is only bypassed for stores
        e.issue.store_data = (d.op2_sel == op2_s_imm) ? st_fwd : shadow[w[24:20]];
        case (d.op2_sel)
            op2_rs2:   e.issue.op2 = rs2_fwd;
            op2_i_imm: e.issue.op2 = {{20{w[31]}}, w[31:20]};
            op2_s_imm: e.issue.op2 = {{20{w[31]}}, w[31:25], w[11:7]};
            op2_u_imm: e.issue.op2 = {w[31:12], 12'b0};
            default:   e.issue.op2 = 32'd0;
        endcase
        return e;
    endfunction

    function automatic reg_addr_t pick_addr();
        logic [31:0] r;
        r = $random(seed);
        return {3'b000, r[1:0]};
    endfunction

    function automatic stage_wr_t random_claim();
        stage_wr_t   c;
        logic [31:0] r;
        r = $random(seed);
        c.wr_addr = {3'b000, r[1:0]};
        c.wr_en   = r[2];
        c.wb_sel  = wb_sel_e'(r[4:3]);
        return c;
    endfunction

    task automatic drive_random();
        logic [31:0] w;
        logic [31:0] f;
        logic [31:0] r;
        w = $random(seed);
        w[19:15] = pick_addr();
        w[24:20] = pick_addr();
        w[11:7]  = pick_addr();
        f = $random(seed);
        f[19:15] = pick_addr();
        f[24:20] = pick_addr();
        r = $random(seed);
        if_instr     = f;
        dec.instr    = w;
        dec.wr_en    = r[0];
        dec.wb_sel   = wb_sel_e'(r[2:1]);
        dec.op2_sel  = op2_sel_e'(r[5:3] % 3'd5);
        branch_taken = (r[8:6] == 3'd0);
        exe_wr       = random_claim();
        mem_wr       = random_claim();
        wb_wr        = random_claim();
        exe_alu_out  = $random(seed);
        mem_result   = $random(seed);
        wb_data      = $random(seed);
    endtask

    // idle pipeline, decode reads register idx and 31-idx
    task automatic drive_read_sweep(input int idx);
        logic [31:0] w;
        w = 32'd0;
        w[19:15] = idx[4:0];
        w[24:20] = 5'd31 - idx[4:0];
        if_instr     = '0;
        dec          = '0;
        dec.instr    = w;
        dec.op2_sel  = op2_rs2;
        exe_wr       = '0;
        mem_wr       = '0;
        wb_wr        = '0;
        exe_alu_out  = 32'd0;
        mem_result   = 32'd0;
        wb_data      = 32'd0;
        branch_taken = 1'b0;
    endtask

    task automatic check_issue(input issue_t exp);
        assert (issue.valid === exp.valid) else begin
            issue_errors++;
            $display("mismatch at %0t: issue.valid got %b expected %b",
                     $time, issue.valid, exp.valid);
        end
        assert (issue.op1 === exp.op1) else begin
            issue_errors++;
            $display("mismatch at %0t: issue.op1 got %h expected %h", $time, issue.op1, exp.op1);
        end
        assert (issue.op2 === exp.op2) else begin
            issue_errors++;
            $display("mismatch at %0t: issue.op2 got %h expected %h", $time, issue.op2, exp.op2);
        end
        assert (issue.store_data === exp.store_data) else begin
            issue_errors++;
            $display("mismatch at %0t: issue.store_data got %h expected %h",
                     $time, issue.store_data, exp.store_data);
        end
        assert ({issue.rd, issue.wr_en, issue.wb_sel} === {exp.rd, exp.wr_en, exp.wb_sel}) else begin
            issue_errors++;
            $display("mismatch at %0t: issue rd/wr_en/wb_sel got %h/%b/%0d expected %h/%b/%0d",
                     $time, issue.rd, issue.wr_en, issue.wb_sel, exp.rd, exp.wr_en, exp.wb_sel);
        end
    endtask

    // checks on the falling edge, where driven inputs and outputs are settled
    initial begin : compare
        expect_t exp_now;
        expect_t pending;
        logic    have_pending;
        have_pending = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                if (have_pending) begin
                    check_issue(pending.issue);
                    issue_checks++;
                end
                exp_now = ref_issue(if_instr, dec, exe_wr, mem_wr, wb_wr,
                                    exe_alu_out, mem_result, wb_data, branch_taken);
                assert ({pc_write_en, if_kill} === {exp_now.pc_write_en, exp_now.if_kill}) else begin
                    control_errors++;
                    $display("mismatch at %0t: pc_write_en/if_kill got %b%b expected %b%b", $time,
                             pc_write_en, if_kill, exp_now.pc_write_en, exp_now.if_kill);
                end
                // writeback lands at the coming edge
                if (wb_wr.wr_en && wb_wr.wr_addr != 5'd0) begin
                    shadow[wb_wr.wr_addr] = wb_data;
                end
                pending      = exp_now;
                have_pending = 1'b1;
            end
        end
    end

    initial begin
        int waited;
        seed           = 49846;
        control_errors = 0;
        issue_errors   = 0;
        timeout_errors = 0;
        issue_checks   = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        arst_n = 1'b0;
        drive_read_sweep(0);
        repeat (8) @(posedge clk);
        #1;
        assert (issue.valid === 1'b0 && issue.wr_en === 1'b0) else begin
            issue_errors++;
            $display("mismatch at %0t: issue valid or wr_en set during reset", $time);
        end
        arst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            drive_read_sweep(i);
            @(posedge clk);
            #1;
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            drive_random();
            @(posedge clk);
            #1;
        end
        drive_read_sweep(0);
        waited = 0;
        while (issue_checks < TOTAL_CHECKS && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (issue_checks < TOTAL_CHECKS) begin
            timeout_errors++;
            $display("timeout: only %0d of %0d issue bundles were compared",
                     issue_checks, TOTAL_CHECKS);
        end
        $display("errors: control %0d, issue %0d, timeout %0d",
                 control_errors, issue_errors, timeout_errors);
        if (control_errors == 0 && issue_errors == 0 && timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog/operand_supply_top.sv */
// decode-stage operand supply top, wiring register file, hazard, bypass and issue blocks
module operand_supply_top #(
    parameter int XLEN = rv_operand_pkg::XLEN
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  rv_operand_pkg::instr_u    if_instr,
    input  rv_operand_pkg::dec_ctrl_t dec,
    input  rv_operand_pkg::stage_wr_t exe_wr,
    input  rv_operand_pkg::stage_wr_t mem_wr,
    input  rv_operand_pkg::stage_wr_t wb_wr,
    input  logic [XLEN-1:0]           exe_alu_out,
    input  logic [XLEN-1:0]           mem_result,
    input  logic [XLEN-1:0]           wb_data,
    input  logic                      branch_taken,
    output logic                      pc_write_en,
    output logic                      if_kill,
    output rv_operand_pkg::issue_t    issue
);
    import rv_operand_pkg::*;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            dec_kill;
    fwd_t            fwd;

    register_file #(
        .XLEN(XLEN)
    ) i_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_addr(dec.instr.r_view.rs1),
        .rs2_addr(dec.instr.r_view.rs2),
        .wr      (wb_wr),
        .wr_data (wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    hazard_stall_unit i_hazard_stall_unit (
        .if_instr    (if_instr),
        .dec         (dec),
        .branch_taken(branch_taken),
        .pc_write_en (pc_write_en),
        .if_kill     (if_kill),
        .dec_kill    (dec_kill)
    );

    forwarding_select_unit i_forwarding_select_unit (
        .dec   (dec),
        .exe_wr(exe_wr),
        .mem_wr(mem_wr),
        .wb_wr (wb_wr),
        .fwd   (fwd)
    );

    decode_issue #(
        .XLEN(XLEN)
    ) i_decode_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec        (dec),
        .fwd        (fwd),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .exe_alu_out(exe_alu_out),
        .mem_result (mem_result),
        .wb_data    (wb_data),
        .dec_kill   (dec_kill),
        .issue      (issue)
    );

endmodule

/* verilog/decode_issue.sv */
// builds and registers the execute-stage issue bundle from reads, bypasses and immediates
module decode_issue #(
    parameter int XLEN = rv_operand_pkg::XLEN
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  rv_operand_pkg::dec_ctrl_t dec,
    input  rv_operand_pkg::fwd_t      fwd,
    input  logic [XLEN-1:0]           rs1_data,
    input  logic [XLEN-1:0]           rs2_data,
    input  logic [XLEN-1:0]           exe_alu_out,
    input  logic [XLEN-1:0]           mem_result,
    input  logic [XLEN-1:0]           wb_data,
    input  logic                      dec_kill,
    output rv_operand_pkg::issue_t    issue
);
    import rv_operand_pkg::*;

    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] op1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] store_val;
    issue_t          issue_d;

    // one bypass mux shared by all three operands
    function automatic logic [XLEN-1:0] bypass(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] exe_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            fwd_exe_alu_out: return exe_val;
            fwd_mem_result:  return mem_val;
            fwd_wb_data:     return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    // I from funct7:rs2, S from the split store fields, U from the upper bits
    assign i_imm = {{(XLEN-12){dec.instr.r_view.funct7[6]}},
                    dec.instr.r_view.funct7, dec.instr.r_view.rs2};
    assign s_imm = {{(XLEN-12){dec.instr.s_view.imm_hi[6]}},
                    dec.instr.s_view.imm_hi, dec.instr.s_view.imm_lo};
    assign u_imm = {{(XLEN-32){dec.instr.r_view.funct7[6]}},
                    dec.instr.r_view.funct7, dec.instr.r_view.rs2,
                    dec.instr.r_view.rs1, dec.instr.r_view.funct3, 12'b0};

    assign op1_val   = bypass(fwd.op1_sel, rs1_data, exe_alu_out, mem_result, wb_data);
    assign rs2_val   = bypass(fwd.op2_sel, rs2_data, exe_alu_out, mem_result, wb_data);
    assign store_val = bypass(fwd.rs2_sel, rs2_data, exe_alu_out, mem_result, wb_data);

    always_comb begin
        issue_d.valid      = !dec_kill;
        issue_d.op1        = op1_val;
        issue_d.store_data = store_val;
        issue_d.rd         = dec.instr.r_view.rd;
        issue_d.wr_en      = dec.wr_en;
        issue_d.wb_sel     = dec.wb_sel;
        case (dec.op2_sel)
            op2_rs2:   issue_d.op2 = rs2_val;
            op2_i_imm: issue_d.op2 = i_imm;
            op2_s_imm: issue_d.op2 = s_imm;
            op2_u_imm: issue_d.op2 = u_imm;
            default:   issue_d.op2 = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue <= '0;
        end else begin
            issue <= issue_d;
        end
    end

endmodule

/* verilog/forwarding_select_unit.sv */
// picks the bypass source for operand 1, operand 2 and store data by stage age
module forwarding_select_unit (
    input  rv_operand_pkg::dec_ctrl_t dec,
    input  rv_operand_pkg::stage_wr_t exe_wr,
    input  rv_operand_pkg::stage_wr_t mem_wr,
    input  rv_operand_pkg::stage_wr_t wb_wr,
    output rv_operand_pkg::fwd_t      fwd
);
    import rv_operand_pkg::*;

    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    logic      dec_has_rs2;
    logic      dec_is_store;

    logic exe_is_arith;
    logic mem_is_arith;
    logic wb_is_arith;
    logic mem_is_load;
    logic wb_is_load;

    // candidate producers, x0 never forwards
    logic exe_ok;
    logic mem_ok;
    logic wb_ok;

    assign dec_rs1      = dec.instr.r_view.rs1;
    assign dec_rs2      = dec.instr.r_view.rs2;
    assign dec_has_rs2  = (dec.op2_sel == op2_rs2);
    assign dec_is_store = (dec.op2_sel == op2_s_imm);

    assign exe_is_arith = exe_wr.wr_en && (exe_wr.wb_sel == wb_alu_out);
    assign mem_is_arith = mem_wr.wr_en && (mem_wr.wb_sel == wb_alu_out);
    assign wb_is_arith  = wb_wr.wr_en && (wb_wr.wb_sel == wb_alu_out);
    assign mem_is_load  = mem_wr.wr_en && (mem_wr.wb_sel == wb_mem_read_data);
    assign wb_is_load   = wb_wr.wr_en && (wb_wr.wb_sel == wb_mem_read_data);

    // exe load data is not ready yet, so only arithmetic counts there
    assign exe_ok = exe_is_arith && (exe_wr.wr_addr != '0);
    assign mem_ok = (mem_is_arith || mem_is_load) && (mem_wr.wr_addr != '0);
    assign wb_ok  = (wb_is_arith || wb_is_load) && (wb_wr.wr_addr != '0);

    always_comb begin
        if (exe_ok && (exe_wr.wr_addr == dec_rs1)) begin
            fwd.op1_sel = fwd_exe_alu_out;
        end else if (mem_ok && (mem_wr.wr_addr == dec_rs1)) begin
            fwd.op1_sel = fwd_mem_result;
        end else if (wb_ok && (wb_wr.wr_addr == dec_rs1)) begin
            fwd.op1_sel = fwd_wb_data;
        end else begin
            fwd.op1_sel = fwd_none;
        end
    end

    // a store keeps op2 on the S immediate, its data goes through rs2_sel
    always_comb begin
        fwd.op2_sel = fwd_none;
        fwd.rs2_sel = fwd_none;
        if (dec_has_rs2 && exe_ok && (exe_wr.wr_addr == dec_rs2)) begin
            fwd.op2_sel = fwd_exe_alu_out;
        end else if ((dec_has_rs2 || dec_is_store) && mem_ok &&
                     (mem_wr.wr_addr == dec_rs2)) begin
            if (dec_is_store) begin
                fwd.rs2_sel = fwd_mem_result;
            end else begin
                fwd.op2_sel = fwd_mem_result;
            end
        end else if ((dec_has_rs2 || dec_is_store) && wb_ok &&
                     (wb_wr.wr_addr == dec_rs2)) begin
            if (dec_is_store) begin
                fwd.rs2_sel = fwd_wb_data;
            end else begin
                fwd.op2_sel = fwd_wb_data;
            end
        end
    end

endmodule

/* verilog/hazard_stall_unit.sv */
// load-use stall and branch flush control for the fetch and decode stages
module hazard_stall_unit (
    input  rv_operand_pkg::instr_u    if_instr,
    input  rv_operand_pkg::dec_ctrl_t dec,
    input  logic                      branch_taken,
    output logic                      pc_write_en,
    output logic                      if_kill,
    output logic                      dec_kill
);
    import rv_operand_pkg::*;

    logic      dec_is_load;
    reg_addr_t dec_rd;
    logic      load_use;

    assign dec_rd      = dec.instr.r_view.rd;
    assign dec_is_load = dec.wr_en && (dec.wb_sel == wb_mem_read_data);

    // rs2 field compared even for I/U forms, a harmless extra stall
    assign load_use = dec_is_load && (dec_rd != '0) &&
                      ((dec_rd == if_instr.r_view.rs1) ||
                       (dec_rd == if_instr.r_view.rs2));

    always_comb begin
        if (branch_taken) begin
            // flush both younger stages
            pc_write_en = 1'b1;
            if_kill     = 1'b1;
            dec_kill    = 1'b1;
        end else if (load_use) begin
            // hold pc, bubble into decode next cycle
            pc_write_en = 1'b0;
            if_kill     = 1'b1;
            dec_kill    = 1'b0;
        end else begin
            pc_write_en = 1'b1;
            if_kill     = 1'b0;
            dec_kill    = 1'b0;
        end
    end

endmodule

/* verilog/register_file.sv */
// integer register file with two combinational reads and one clocked write port from writeback
module register_file #(
    parameter int XLEN = rv_operand_pkg::XLEN
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv_operand_pkg::reg_addr_t rs1_addr,
    input  rv_operand_pkg::reg_addr_t rs2_addr,
    input  rv_operand_pkg::stage_wr_t wr,
    input  logic [XLEN-1:0]          wr_data,
    output logic [XLEN-1:0]          rs1_data,
    output logic [XLEN-1:0]          rs2_data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            wr_fire;

    assign wr_fire = wr.wr_en && (wr.wr_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            regs[wr.wr_addr] <= wr_data;
        end
    end

    // reads see the old value during a write, wb forwarding covers that
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* verilog/rv_operand_pkg.sv */
// shared types and encodings for the decode-stage operand supply, imported by every block
package rv_operand_pkg;

    // default data width, overridden only through the top-level parameter
    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    // writeback source of a pipeline stage
    typedef enum logic [1:0] {
        wb_none          = 2'd0,
        wb_alu_out       = 2'd1,
        wb_mem_read_data = 2'd2,
        wb_pc_plus4      = 2'd3
    } wb_sel_e;

    // operand 2 source chosen by the control decoder
    typedef enum logic [2:0] {
        op2_rs2   = 3'd0,
        op2_i_imm = 3'd1,
        op2_s_imm = 3'd2,
        op2_u_imm = 3'd3,
        op2_zero  = 3'd4
    } op2_sel_e;

    // where a decode operand is taken from
    typedef enum logic [1:0] {
        fwd_none        = 2'd0,
        fwd_exe_alu_out = 2'd1,
        fwd_mem_result  = 2'd2,
        fwd_wb_data     = 2'd3
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    // store layout, rd bits carry the low immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // same instruction word, two decodings
    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } instr_u;

    // writeback claim reported by exe, mem or wb
    typedef struct packed {
        reg_addr_t wr_addr;
        logic      wr_en;
        wb_sel_e   wb_sel;
    } stage_wr_t;

    typedef struct packed {
        instr_u   instr;
        logic     wr_en;
        wb_sel_e  wb_sel;
        op2_sel_e op2_sel;
    } dec_ctrl_t;

    typedef struct packed {
        fwd_sel_e op1_sel;
        fwd_sel_e op2_sel;
        fwd_sel_e rs2_sel;
    } fwd_t;

    // bundle handed to the execute stage
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] store_data;
        reg_addr_t       rd;
        logic            wr_en;
        wb_sel_e         wb_sel;
    } issue_t;

endpackage
